//--- address_decode.sv
// CPU address decoder; turns a system address into chip selects plus read-only and mirror flags
`timescale 1ns/1ps
`default_nettype none

module address_decode (
    input  wire  [pet_pkg::addr_w-1:0] addr,
    output logic                       ram_enable,     // Anything outside the I/O page
    output logic                       io_enable,      // Whole I/O page $E800..$E8FF
    output logic                       pia1_enable,
    output logic                       pia2_enable,
    output logic                       via_enable,
    output logic                       is_readonly,    // ROM images in RAM
    output logic                       is_mirrored     // Video RAM window
);

    logic low_ram;
    logic vram;
    logic rom;
    logic io_page;

    // Range compares against the package map
    assign low_ram = (addr <= pet_pkg::ram_top);
    assign vram    = (addr >= pet_pkg::vram_base) && (addr <= pet_pkg::vram_top);
    assign rom     = (addr >= pet_pkg::rom_base) && (addr <= pet_pkg::rom_top);
    assign io_page = (addr >= pet_pkg::io_base) && (addr <= pet_pkg::io_top);

    // RAM answers everywhere except the I/O page
    assign ram_enable = low_ram || vram || rom ||
                        ((addr > pet_pkg::rom_top) && !io_page);    // Editor/kernal area
    assign io_enable  = io_page;

    // Each peripheral decodes 16 bytes, compare above bit 4
    assign pia1_enable = (addr[pet_pkg::addr_w-1:4] == pet_pkg::pia1_base[pet_pkg::addr_w-1:4]);
    assign pia2_enable = (addr[pet_pkg::addr_w-1:4] == pet_pkg::pia2_base[pet_pkg::addr_w-1:4]);
    assign via_enable  = (addr[pet_pkg::addr_w-1:4] == pet_pkg::via_base[pet_pkg::addr_w-1:4]);

    assign is_readonly = rom;       // CPU writes into ROM area are dropped
    assign is_mirrored = vram;      // A11/A10 forced low by top level

endmodule

`default_nettype wire

//--- bus_timing.sv
// 16-phase bus cycle sequencer; instantiate once per system to get clk8, phi2 and the slot strobes
`timescale 1ns/1ps
`default_nettype none

module bus_timing (
    input  wire  clk16,             // 16 MHz master clock
    input  wire  rst_n,
    output logic clk8,              // High on even phases
    output logic phi2,              // CPU clock, high in 12..15
    output logic cpu_enable,        // CPU slot 8..15
    output logic pi_select,         // Host slot 0..3
    output logic pi_enable,         // Host strobe phase
    output logic video_select,      // Video slot 4..7
    output logic video_ram_strobe,
    output logic video_rom_strobe
);

    // Counter runs one phase ahead of the outputs
    // so every output is a registered decode of the phase about to start
    logic [pet_pkg::phase_w-1:0] phase;

    always_ff @(posedge clk16 or negedge rst_n) begin
        if (!rst_n) begin
            phase            <= pet_pkg::ph_pi_first;   // First phase out is the host slot
            clk8             <= 1'b0;
            phi2             <= 1'b0;
            cpu_enable       <= 1'b0;
            pi_select        <= 1'b0;
            pi_enable        <= 1'b0;
            video_select     <= 1'b0;
            video_ram_strobe <= 1'b0;
            video_rom_strobe <= 1'b0;
        end else begin
            phase <= phase + 1'b1;                      // Wraps at 16

            clk8 <= ~phase[0];                          // Even phase coming up

            // Host slot starts at phase 0, so only the upper bound matters
            pi_select <= (phase <= pet_pkg::ph_pi_last);
            pi_enable <= (phase == pet_pkg::ph_pi_strobe);

            // Video slot
            video_select     <= (phase >= pet_pkg::ph_vid_first) &&
                                (phase <= pet_pkg::ph_vid_last);
            video_ram_strobe <= (phase == pet_pkg::ph_vram_strobe);
            video_rom_strobe <= (phase == pet_pkg::ph_vrom_strobe);

            // CPU slot fills the rest of the cycle
            cpu_enable <= (phase >= pet_pkg::ph_cpu_first);
            phi2       <= (phase >= pet_pkg::ph_phi2_first);    // Second half of CPU slot
        end
    end

endmodule

`default_nettype wire

//--- keyboard.sv
// Keyboard matrix filled by the host; snoops the PIA1 row select and answers CPU reads of port B
`timescale 1ns/1ps
`default_nettype none

module keyboard (
    input  wire                        clk16,
    input  wire                        rst_n,
    input  wire                        pi_write,       // Host write strobe
    input  wire  [pet_pkg::addr_w-1:0] pi_addr,
    input  wire  [pet_pkg::data_w-1:0] pi_wr_data,
    input  wire  [pet_pkg::addr_w-1:0] cpu_addr,
    input  wire  [pet_pkg::data_w-1:0] cpu_wr_data,
    input  wire                        cpu_write,      // phi2 qualified
    input  wire                        cpu_read,       // phi2 qualified
    input  wire                        pia1_enable,    // From decoder, before suppression
    output logic                       kbd_enable,     // Intercepting a port B read
    output logic [pet_pkg::data_w-1:0] kbd_data
);

    logic [pet_pkg::data_w-1:0] rows [pet_pkg::kbd_rows];  // Active-low key bits
    logic [3:0]                 row_sel;                   // PIA1 port A low nibble
    logic [3:0]                 host_row;
    logic                       host_hit;
    logic                       sel_valid;

    // Host writes row N at kbd_row_base + N
    assign host_row = pi_addr[3:0];
    assign host_hit = pi_write &&
                      (pi_addr[pet_pkg::addr_w-1:4] == pet_pkg::kbd_row_base[pet_pkg::addr_w-1:4]) &&
                      (host_row < 4'(pet_pkg::kbd_rows));

    always_ff @(posedge clk16 or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pet_pkg::kbd_rows; i++) begin
                rows[i] <= '1;                  // No key pressed
            end
            row_sel <= 4'd0;
        end else begin
            if (host_hit)
                rows[host_row] <= pi_wr_data;
            if (cpu_write && (cpu_addr == pet_pkg::kbd_port_a))
                row_sel <= cpu_wr_data[3:0];    // Snoop, PIA still takes the write
        end
    end

    // Rows 10..15 do not exist on the matrix
    assign sel_valid = (row_sel < 4'(pet_pkg::kbd_rows));

    // Port B read is answered here instead of by PIA1
    assign kbd_enable = cpu_read && pia1_enable && (cpu_addr == pet_pkg::kbd_port_b);
    assign kbd_data   = sel_valid ? rows[row_sel] : '1;

endmodule

`default_nettype wire

//--- pet_main.sv
// Top level of the PET bus core; ties timing, host access, decoding and keyboard to the board pins
`timescale 1ns/1ps
`default_nettype none

module pet_main (
    input  wire                        clk16,
    input  wire                        rst_n,
    // CPU side
    input  wire  [pet_pkg::addr_w-1:0] cpu_addr,
    input  wire                        cpu_rw_b,       // 1 read, 0 write
    input  wire  [pet_pkg::data_w-1:0] cpu_wr_data,
    // Host side
    input  wire  [pet_pkg::addr_w-1:0] pi_addr,
    input  wire                        pi_rw_b,
    input  wire  [pet_pkg::data_w-1:0] pi_wr_data,
    input  wire                        pi_pending,
    input  wire                        gfx,
    // Video fetcher
    input  wire  [11:0]                video_addr,     // Offset into video RAM
    input  wire  [pet_pkg::data_w-1:0] bus_data_in,
    output logic                       clk8,
    output logic                       phi2,
    output logic                       pi_done,
    output logic [pet_pkg::data_w-1:0] pi_rd_data,
    output logic                       res_b,
    output logic                       cpu_rdy,
    output logic                       cpu_be,         // CPU bus enable
    output logic                       ram_ce_b,
    output logic                       ram_oe_b,
    output logic                       ram_we_b,
    output logic [11:10]               ram_addr,       // Intercepted A11/A10
    output logic                       pia1_cs2_b,
    output logic                       pia2_cs2_b,
    output logic                       via_cs2_b,
    output logic                       io_oe_b,
    output logic                       video_ram_strobe,
    output logic                       video_rom_strobe,
    output logic [pet_pkg::addr_w-1:0] bus_addr,
    output logic                       bus_addr_oe,
    output logic [pet_pkg::data_w-1:0] bus_data_out,
    output logic                       bus_data_oe
);

    logic cpu_enable, pi_select, pi_enable, video_select;
    logic pi_strobe, pi_read, pi_write, cpu_read, cpu_write;
    logic ram_enable, io_enable, pia1_enable, pia2_enable, via_enable;
    logic is_readonly, is_mirrored, kbd_enable;
    logic [pet_pkg::data_w-1:0] kbd_data;

    bus_timing u_timing (
        .clk16(clk16), .rst_n(rst_n), .clk8(clk8), .phi2(phi2), .cpu_enable(cpu_enable),
        .pi_select(pi_select), .pi_enable(pi_enable), .video_select(video_select),
        .video_ram_strobe(video_ram_strobe), .video_rom_strobe(video_rom_strobe)
    );

    pi_sync u_sync (
        .clk16(clk16), .rst_n(rst_n), .pi_select(pi_select), .pi_enable(pi_enable),
        .pi_pending(pi_pending), .pi_done(pi_done), .pi_strobe(pi_strobe)
    );

    address_decode u_decode (
        .addr(cpu_addr), .ram_enable(ram_enable), .io_enable(io_enable),
        .pia1_enable(pia1_enable), .pia2_enable(pia2_enable), .via_enable(via_enable),
        .is_readonly(is_readonly), .is_mirrored(is_mirrored)
    );

    pi_ctl u_ctl (
        .clk16(clk16), .rst_n(rst_n), .pi_write(pi_write), .pi_read(pi_read),
        .pi_addr(pi_addr), .pi_wr_data(pi_wr_data), .bus_data_in(bus_data_in),
        .gfx(gfx), .res_b(res_b), .rdy(cpu_rdy), .pi_rd_data(pi_rd_data)
    );

    keyboard u_kbd (
        .clk16(clk16), .rst_n(rst_n), .pi_write(pi_write), .pi_addr(pi_addr),
        .pi_wr_data(pi_wr_data), .cpu_addr(cpu_addr), .cpu_wr_data(cpu_wr_data),
        .cpu_write(cpu_write), .cpu_read(cpu_read), .pia1_enable(pia1_enable),
        .kbd_enable(kbd_enable), .kbd_data(kbd_data)
    );

    // Access qualifiers
    assign pi_read   = pi_strobe && pi_rw_b;
    assign pi_write  = pi_strobe && !pi_rw_b;
    assign cpu_read  = phi2 && cpu_rw_b;
    assign cpu_write = phi2 && !cpu_rw_b;
    assign cpu_be    = cpu_enable && cpu_rdy;   // CPU floats its bus while halted

    // Chip selects, PIA1 stays off while keyboard answers
    assign pia1_cs2_b = !(pia1_enable && !kbd_enable && cpu_be);
    assign pia2_cs2_b = !(pia2_enable && cpu_be);
    assign via_cs2_b  = !(via_enable && cpu_be);
    assign io_oe_b    = !(io_enable && cpu_be);

    // RAM controls
    assign ram_ce_b = !(pi_select || video_select || (ram_enable && cpu_be));
    assign ram_oe_b = !(pi_read || video_select || (cpu_read && cpu_be));
    assign ram_we_b = !(pi_write || (cpu_write && cpu_be && !is_readonly));

    // Video RAM mirroring on A11/A10
    always_comb begin
        if (pi_select)
            ram_addr = pi_addr[11:10];          // Host sees the whole RAM
        else if (video_select)
            ram_addr = video_addr[11:10];
        else if (is_mirrored)
            ram_addr = 2'b00;                   // CPU VRAM accesses fold to first 1 KB
        else
            ram_addr = cpu_addr[11:10];
    end

    // Address bus, CPU drives it itself in its slot
    assign bus_addr_oe = pi_select || video_select;
    always_comb begin
        if (pi_select)
            bus_addr = pi_addr;
        else if (video_select)
            bus_addr = pet_pkg::vram_base | {5'd0, video_addr};
        else
            bus_addr = cpu_addr;                // Shown only, not driven
    end

    // Data bus, host write data or intercepted keyboard row
    assign bus_data_oe  = pi_write || kbd_enable;
    assign bus_data_out = pi_write ? pi_wr_data : kbd_data;

endmodule

`default_nettype wire

//--- pet_main_sva.sv
// Timing and handshake assertions for the PET bus core; bound into pet_main by the bind at the end
`timescale 1ns/1ps
`default_nettype none

module pet_main_sva (
    input wire clk16,
    input wire rst_n,
    input wire phi2,
    input wire cpu_enable,
    input wire pi_select,
    input wire video_select,
    input wire pi_pending,
    input wire pi_done,
    input wire ram_we_b,
    input wire ram_oe_b
);

    phi2_in_cpu_slot: assert property (@(posedge clk16) disable iff (!rst_n)
        phi2 |-> cpu_enable) else $error("phi2 high outside the CPU slot");

    one_slot: assert property (@(posedge clk16) disable iff (!rst_n)
        $onehot0({pi_select, video_select, cpu_enable})) else $error("Two slot selects high");

    // Done is held while the host still requests
    done_held: assert property (@(posedge clk16) disable iff (!rst_n)
        pi_done && pi_pending |=> pi_done) else $error("pi_done fell with pi_pending high");

    no_bus_fight: assert property (@(posedge clk16) disable iff (!rst_n)
        !(!ram_we_b && !ram_oe_b)) else $error("ram_we_b and ram_oe_b low together");

endmodule

bind pet_main pet_main_sva u_sva (
    .clk16(clk16), .rst_n(rst_n), .phi2(phi2), .cpu_enable(cpu_enable),
    .pi_select(pi_select), .video_select(video_select), .pi_pending(pi_pending),
    .pi_done(pi_done), .ram_we_b(ram_we_b), .ram_oe_b(ram_oe_b)
);

`default_nettype wire

//--- pet_pkg.sv
// Shared phase numbers, address map and register addresses for the PET bus core; use by scoped name
`default_nettype none

package pet_pkg;

    // Bus cycle sequencing
    localparam int unsigned phase_w = 4;                        // 16 phases per 1 MHz cycle

    // Host slot
    localparam logic [phase_w-1:0] ph_pi_first    = 4'd0;
    localparam logic [phase_w-1:0] ph_pi_last     = 4'd3;
    localparam logic [phase_w-1:0] ph_pi_strobe   = 4'd2;       // Host access strobe

    // Video slot
    localparam logic [phase_w-1:0] ph_vid_first   = 4'd4;
    localparam logic [phase_w-1:0] ph_vid_last    = 4'd7;
    localparam logic [phase_w-1:0] ph_vram_strobe = 4'd5;       // Character code fetch
    localparam logic [phase_w-1:0] ph_vrom_strobe = 4'd7;       // Character ROM fetch

    // CPU slot, runs to the end of the cycle
    localparam logic [phase_w-1:0] ph_cpu_first   = 4'd8;
    localparam logic [phase_w-1:0] ph_phi2_first  = 4'd12;      // phi2 high in 12..15

    // Widths
    localparam int unsigned addr_w = 17;                        // Includes upper bank bit
    localparam int unsigned data_w = 8;

    // Address map
    localparam logic [addr_w-1:0] ram_top   = 17'h0_7FFF;
    localparam logic [addr_w-1:0] vram_base = 17'h0_8000;       // Mirrored video RAM
    localparam logic [addr_w-1:0] vram_top  = 17'h0_8FFF;
    localparam logic [addr_w-1:0] rom_base  = 17'h0_9000;       // Read-only for the CPU
    localparam logic [addr_w-1:0] rom_top   = 17'h0_DFFF;
    localparam logic [addr_w-1:0] io_base   = 17'h0_E800;
    localparam logic [addr_w-1:0] io_top    = 17'h0_E8FF;
    localparam logic [addr_w-1:0] pia1_base = 17'h0_E810;       // 16 bytes each
    localparam logic [addr_w-1:0] pia2_base = 17'h0_E820;
    localparam logic [addr_w-1:0] via_base  = 17'h0_E840;

    // Registers inside the I/O page
    localparam logic [addr_w-1:0] kbd_row_base = 17'h0_E800;    // Host loads rows 0..9 here
    localparam logic [addr_w-1:0] reg_gfx      = 17'h0_E80E;    // Graphics jumper status
    localparam logic [addr_w-1:0] reg_ctl      = 17'h0_E80F;    // Bit 0 res_b, bit 1 rdy
    localparam logic [addr_w-1:0] kbd_port_a   = 17'h0_E810;    // PIA1 port A, row select
    localparam logic [addr_w-1:0] kbd_port_b   = 17'h0_E812;    // PIA1 port B, intercepted

    // Keyboard matrix size
    localparam int unsigned kbd_rows = 10;

endpackage

`default_nettype wire

//--- pi_ctl.sv
// Host control register and host read-data latch; holds CPU reset/ready and returns host read data
`timescale 1ns/1ps
`default_nettype none

module pi_ctl (
    input  wire                        clk16,
    input  wire                        rst_n,
    input  wire                        pi_write,       // Host write strobe
    input  wire                        pi_read,        // Host read strobe
    input  wire  [pet_pkg::addr_w-1:0] pi_addr,
    input  wire  [pet_pkg::data_w-1:0] pi_wr_data,
    input  wire  [pet_pkg::data_w-1:0] bus_data_in,    // Data returned from RAM
    input  wire                        gfx,            // Graphics jumper
    output logic                       res_b,          // CPU reset, active low
    output logic                       rdy,            // CPU ready
    output logic [pet_pkg::data_w-1:0] pi_rd_data
);

    wire ctl_hit = (pi_addr == pet_pkg::reg_ctl);
    wire gfx_hit = (pi_addr == pet_pkg::reg_gfx);

    // CPU held in reset and halted until the host lets it go
    always_ff @(posedge clk16 or negedge rst_n) begin
        if (!rst_n) begin
            res_b <= 1'b0;
            rdy   <= 1'b0;
        end else if (pi_write && ctl_hit) begin
            res_b <= pi_wr_data[0];
            rdy   <= pi_wr_data[1];
        end
    end

    // Capture read data on the strobe clock, RAM output is valid then
    always_ff @(posedge clk16) begin
        if (pi_read) begin
            if (gfx_hit)
                pi_rd_data <= {{(pet_pkg::data_w-1){1'b0}}, gfx};   // Jumper in bit 0
            else
                pi_rd_data <= bus_data_in;
        end
    end

endmodule

`default_nettype wire

//--- pi_sync.sv
// Host pending/done handshake; turns one host request into a single strobe inside the host slot
`timescale 1ns/1ps
`default_nettype none

module pi_sync (
    input  wire  clk16,
    input  wire  rst_n,
    input  wire  pi_select,         // Host slot, phases 0..3
    input  wire  pi_enable,         // Strobe phase inside host slot
    input  wire  pi_pending,        // Request from host
    output logic pi_done,           // Request finished, held until pending drops
    output logic pi_strobe          // One access per request
);

    typedef enum logic [1:0] {
        st_idle,                    // Waiting for a request at slot start
        st_granted,                 // Access happens in this slot
        st_done                     // Waiting for host to drop pending
    } state_t;

    state_t state;
    logic   pi_select_q;            // Previous pi_select, finds phase 0

    wire slot_start = pi_select && !pi_select_q;    // First clock of host slot

    always_ff @(posedge clk16 or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            pi_select_q <= 1'b0;
        end else begin
            pi_select_q <= pi_select;
            case (state)
                st_idle:    if (slot_start && pi_pending) state <= st_granted;
                st_granted: if (pi_enable) state <= st_done;    // Done shows in phase 3
                st_done:    if (!pi_pending) state <= st_idle;  // Release one clock later
                default:    state <= st_idle;
            endcase
        end
    end

    assign pi_strobe = (state == st_granted) && pi_enable;
    assign pi_done   = (state == st_done);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the PET bus core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pet_main -f vlog.f -o sim_tb_pet_main

./obj_dir/sim_tb_pet_main 2>&1 | tee sim.log

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1

//--- tb_pet_main.sv
// Testbench for pet_main; drives host and CPU accesses against a RAM model and checks the results
`timescale 1ns/1ps
`default_nettype none

module tb_pet_main;

    logic        clk16, rst_n;
    logic [16:0] cpu_addr, pi_addr, bus_addr;
    logic        cpu_rw_b, pi_rw_b, pi_pending, gfx;
    logic [7:0]  cpu_wr_data, pi_wr_data, bus_data_in, bus_data_out, pi_rd_data;
    logic [11:0] video_addr;
    logic        clk8, phi2, pi_done, res_b, cpu_rdy, cpu_be, ram_ce_b, ram_oe_b, ram_we_b;
    logic [1:0]  ram_addr;
    logic        pia1_cs2_b, pia2_cs2_b, via_cs2_b, io_oe_b;
    logic        video_ram_strobe, video_rom_strobe, bus_addr_oe, bus_data_oe;

    logic [7:0]  mem [0:65535];     // 64 KB board RAM
    logic [15:0] ram_index;         // A11/A10 come from the core
    logic [3:0]  tb_phase;          // Expected bus phase
    logic [1:0]  ctl_val;           // Last value written to the control register
    logic        cmp_en;            // Compare process armed
    logic [8:0]  cmp_exp, cmp_got;
    int          errors, checks;

    pet_main DUT (.*);

    always #4 clk16 = ~clk16;       // 8 ns period

    // RAM model is written on the clock that ends a write and read combinationally
    assign ram_index   = {bus_addr[15:12], ram_addr, bus_addr[9:0]};
    assign bus_data_in = mem[ram_index];
    always @(posedge clk16) begin
        if (!ram_we_b)
            mem[ram_index] <= bus_data_oe ? bus_data_out : cpu_wr_data;
    end

    // First clock after reset release starts phase 0
    always @(posedge clk16 or negedge rst_n) begin
        if (!rst_n) tb_phase <= 4'hF;
        else        tb_phase <= tb_phase + 4'd1;
    end

    // Expected CPU-slot outputs during phi2 from the address map rules
    function automatic logic [8:0] exp_cpu(input logic [16:0] a, input logic rw_b,
                                           input logic rdy);
        logic io, ro, mir, p1, p2, via, kbd;
        io  = (a >= pet_pkg::io_base) && (a <= pet_pkg::io_top);
        ro  = (a >= pet_pkg::rom_base) && (a <= pet_pkg::rom_top);   // Writes dropped
        mir = (a >= pet_pkg::vram_base) && (a <= pet_pkg::vram_top);
        p1  = (a[16:4] == pet_pkg::pia1_base[16:4]);
        p2  = (a[16:4] == pet_pkg::pia2_base[16:4]);
        via = (a[16:4] == pet_pkg::via_base[16:4]);
        kbd = rw_b && (a == pet_pkg::kbd_port_b);                    // Keyboard answers instead of PIA1
        return {!(p1 && !kbd && rdy), !(p2 && rdy), !(via && rdy), !(io && rdy),
                !(!io && rdy), !(rw_b && rdy), !(!rw_b && rdy && !ro), mir ? 2'b00 : a[11:10]};
    endfunction

    // Compares the CPU-slot outputs at the end of each phi2 phase
    always @(posedge clk16) begin
        if (cmp_en && tb_phase >= 4'd12) begin
            cmp_exp = exp_cpu(cpu_addr, cpu_rw_b, ctl_val[1]);
            cmp_got = {pia1_cs2_b, pia2_cs2_b, via_cs2_b, io_oe_b, ram_ce_b, ram_oe_b, ram_we_b,
                       ram_addr};
            checks++;
            if (cmp_got !== cmp_exp) begin
                $display("Mismatch at %0t: cpu_addr %h rw_b %0b gives %b, expected %b",
                         $time, cpu_addr, cpu_rw_b, cmp_got, cmp_exp);
                errors++;
            end
        end
    end

    task automatic abort(input string what);
        $display("%s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %0b, expected %0b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Returns on the falling edge inside phase p
    task automatic wait_phase(input logic [3:0] p);
        int n;
        n = 0;
        @(negedge clk16);
        while (tb_phase != p && n < 20) begin
            @(negedge clk16);
            n++;
        end
        if (tb_phase != p) abort("Timeout waiting for a bus phase");
    endtask

    // One host request through the pending/done handshake
    task automatic host_access(input logic [16:0] addr, input logic rw_b, input logic [7:0] wdata,
                               output logic [7:0] rdata);
        int n;
        @(negedge clk16);
        pi_addr    = addr;
        pi_rw_b    = rw_b;
        pi_wr_data = wdata;
        pi_pending = 1'b1;
        n = 0;
        while (!pi_done && n < 40) begin
            @(negedge clk16);
            n++;
        end
        if (!pi_done) abort("Timeout waiting for pi_done to rise");
        checks++;
        if (n > 19) begin
            $display("Host request at %h took %0d clocks, more than 19", addr, n);
            errors++;
        end
        rdata      = pi_rd_data;            // Latched on the strobe clock
        pi_pending = 1'b0;
        n = 0;
        while (pi_done && n < 40) begin
            @(negedge clk16);
            n++;
        end
        if (pi_done) abort("Timeout waiting for pi_done to fall");
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (errors == errs_at_start) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - errs_at_start);
    endtask

    initial begin
        int          e0, n, phi2_cnt;
        logic [16:0] addrs [8];
        logic [7:0]  datas [8];
        logic [7:0]  rows_exp [10];
        logic [7:0]  rd;
        logic [3:0]  ph;
        int          sel [3];

        void'($urandom(32'h3284_568d));
        for (int i = 0; i < 65536; i++) mem[i] <= 8'(i) ^ 8'(i >> 8);  // Whole-address fill
        clk16       = 1'b0;
        rst_n       = 1'b0;
        cmp_en      = 1'b0;
        ctl_val     = 2'b00;
        errors      = 0;
        checks      = 0;
        cpu_addr    = '0;
        cpu_rw_b    = 1'b1;
        cpu_wr_data = '0;
        video_addr  = '0;
        gfx         = 1'b0;
        pi_addr     = '0;
        pi_rw_b     = 1'b1;
        pi_wr_data  = '0;
        pi_pending  = 1'b0;
        repeat (4) @(negedge clk16);
        rst_n = 1'b1;

        // Slot pattern counted from the first clk8 rise
        e0       = errors;
        n        = 0;
        phi2_cnt = 0;
        while (!clk8 && n < 20) begin
            @(negedge clk16);
            n++;
        end
        if (!clk8) abort("Timeout waiting for clk8 to rise after reset");
        check_byte("phase at first clk8 rise", 8'(tb_phase), 8'd0);
        for (int p = 0; p < 48; p++) begin
            ph = 4'(p);
            check_bit("clk8", clk8, !ph[0]);                    // High on even phases
            check_bit("bus_addr_oe", bus_addr_oe, ph <= 4'd7);  // Host and video slots
            check_bit("phi2", phi2, ph >= 4'd12);
            check_bit("video_ram_strobe", video_ram_strobe, ph == 4'd5);
            check_bit("video_rom_strobe", video_rom_strobe, ph == 4'd7);
            if (phi2) phi2_cnt++;
            if (ph == 4'd15) begin
                check_byte("phi2 clocks per cycle", 8'(phi2_cnt), 8'd4);
                phi2_cnt = 0;
            end
            @(negedge clk16);
        end
        report_test("Slot pattern", e0);

        // Host writes then reads back with distinct upper bits per address
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = {2'b00, 3'(i), 12'($urandom)};
            datas[i] = 8'($urandom);
            host_access(addrs[i], 1'b0, datas[i], rd);
        end
        for (int i = 0; i < 8; i++) begin
            host_access(addrs[i], 1'b1, 8'h00, rd);
            check_byte("host read data", rd, datas[i]);
        end
        report_test("Host write and read-back", e0);

        // Control register values end with the CPU running
        e0 = errors;
        for (int v = 0; v < 4; v++) begin
            host_access(pet_pkg::reg_ctl, 1'b0, 8'(v), rd);
            ctl_val = 2'(v);
            check_bit("res_b", res_b, ctl_val[0]);
            check_bit("cpu_rdy", cpu_rdy, ctl_val[1]);
            wait_phase(4'd0);
            for (int k = 0; k < 16; k++) begin
                check_bit("cpu_be", cpu_be, (tb_phase >= 4'd8) && ctl_val[1]);
                @(negedge clk16);
            end
        end
        report_test("Control register", e0);

        // Address decoding with one address per bus cycle
        e0 = errors;
        for (int k = 0; k < 40; k++) begin
            wait_phase(4'd8);
            case (k)
                0:       cpu_addr = 17'h0_9123;                   // ROM area
                1:       cpu_addr = 17'h0_8C05;                   // Mirrored video RAM
                2:       cpu_addr = 17'h0_E811;
                default: cpu_addr = (k % 2 == 1) ? {9'h0E8, 8'($urandom)} : {1'b0, 16'($urandom)};
            endcase
            cpu_rw_b    = (k == 0) ? 1'b0 : 1'($urandom);
            cpu_wr_data = 8'($urandom);
            cmp_en      = 1'b1;
        end
        wait_phase(4'd0);
        cmp_en = 1'b0;
        report_test("Address decoding", e0);

        // Keyboard intercept where row 12 is off the matrix
        e0     = errors;
        sel[0] = 3;
        sel[1] = 9;
        sel[2] = 12;
        for (int r = 0; r < 10; r++) begin
            rows_exp[r] = 8'($urandom);
            host_access(pet_pkg::kbd_row_base + 17'(r), 1'b0, rows_exp[r], rd);
        end
        for (int s = 0; s < 3; s++) begin
            wait_phase(4'd8);
            cpu_addr    = pet_pkg::kbd_port_a;
            cpu_rw_b    = 1'b0;
            cpu_wr_data = 8'(sel[s]);
            wait_phase(4'd8);
            cpu_addr = pet_pkg::kbd_port_b;
            cpu_rw_b = 1'b1;
            wait_phase(4'd13);
            check_byte("keyboard row", bus_data_out, (sel[s] < 10) ? rows_exp[sel[s]] : 8'hFF);
            check_bit("bus_data_oe", bus_data_oe, 1'b1);
            check_bit("pia1_cs2_b", pia1_cs2_b, 1'b1);
        end
        wait_phase(4'd8);
        cpu_addr = '0;
        cpu_rw_b = 1'b1;
        report_test("Keyboard intercept", e0);

        // Graphics jumper
        e0 = errors;
        for (int g = 0; g < 2; g++) begin
            gfx = g[0];
            host_access(pet_pkg::reg_gfx, 1'b1, 8'h00, rd);
            check_byte("graphics status", rd, {7'b0, g[0]});
        end
        report_test("Graphics status", e0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
pet_pkg.sv
bus_timing.sv
pi_sync.sv
address_decode.sv
pi_ctl.sv
keyboard.sv
pet_main.sv
pet_main_sva.sv
tb_pet_main.sv
